// File: Makefile
SRCS := $(shell grep -v '^+' mips_lsu.f) dv/lsu_tb_ref.svh

obj_dir/Vlsu_tb: mips_lsu.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f mips_lsu.f --top-module lsu_tb -o Vlsu_tb

run: obj_dir/Vlsu_tb
	@out="$$(./obj_dir/Vlsu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: dv/lsu_tb_ref.svh
// reference register and memory model, reference function, compare tasks
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

logic [31:0] rf_m [32];
logic [7:0]  mem_m [RAM_WORDS*4];
int          checks;
int          errors;
string       test_name;

// byte address wraps with the RAM depth
function automatic int baddr(input logic [31:0] a);
    return int'(a % (RAM_WORDS * 4));
endfunction

// byte k counted from the most significant end
function automatic logic [7:0] byte_of(input logic [31:0] w, input int k);
    return w[31-8*k -: 8];
endfunction

function automatic logic [31:0] model_word(input logic [31:0] a);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
        w[31-8*k -: 8] = mem_m[baddr({a[31:2], 2'b00} + k)];
    end
    return w;
endfunction

function automatic wb_t ref_exec(input instr_t i);
    wb_t         r;
    logic [31:0] rt_v;
    logic [31:0] ea;
    logic [31:0] w;
    logic [31:0] res;
    logic [15:0] h;
    logic [7:0]  b;
    logic        writes;
    int          n;
    rt_v   = rf_m[i.rt];
    ea     = rf_m[i.rs] + {{16{i.imm[15]}}, i.imm};
    w      = model_word(ea);
    b      = mem_m[baddr(ea)];
    h      = {b, mem_m[baddr(ea + 1)]};
    n      = int'(ea[1:0]);
    res    = 32'd0;
    writes = 1'b1;
    case (i.opcode)
        OPC_ADDIU: res = ea;
        OPC_LB:    res = {{24{b[7]}}, b};
        OPC_LBU:   res = {24'd0, b};
        OPC_LH:    res = ea[0] ? 32'd0 : {{16{h[15]}}, h};
        OPC_LHU:   res = ea[0] ? 32'd0 : {16'd0, h};
        OPC_LW:    res = w;
        OPC_LWL: begin
            for (int k = 0; k < 4; k++) begin
                res[31-8*k -: 8] = (k + n < 4) ? byte_of(w, k + n) : byte_of(rt_v, k);
            end
        end
        // rt keeps its upper 3-n bytes
        OPC_LWR: begin
            for (int k = 0; k < 4; k++) begin
                res[31-8*k -: 8] = (k < 3 - n) ? byte_of(rt_v, k) : byte_of(w, k - 3 + n);
            end
        end
        default: writes = 1'b0;
    endcase
    case (i.opcode)
        OPC_SB: mem_m[baddr(ea)] = rt_v[7:0];
        OPC_SH: begin
            if (!ea[0]) begin
                mem_m[baddr(ea)]     = rt_v[15:8];
                mem_m[baddr(ea + 1)] = rt_v[7:0];
            end
        end
        OPC_SW: begin
            for (int k = 0; k < 4; k++) begin
                mem_m[baddr(ea - n + k)] = byte_of(rt_v, k);
            end
        end
        OPC_SWL: begin
            for (int k = 0; k < 4 - n; k++) begin
                mem_m[baddr(ea + k)] = byte_of(rt_v, k);
            end
        end
        OPC_SWR: begin
            for (int k = 0; k <= n; k++) begin
                mem_m[baddr(ea - n + k)] = byte_of(rt_v, k + 3 - n);
            end
        end
        default: ;
    endcase
    r.valid = 1'b1;
    r.wreg  = writes && (i.rt != 5'd0);
    r.wd    = i.rt;
    r.wdata = res;
    if (r.wreg) begin
        rf_m[i.rt] = res;
    end
    return r;
endfunction

task automatic report_failure(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
endtask

// wd and wdata only matter when the register file is written
task automatic check_wb(input wb_t exp, input wb_t act);
    checks++;
    if (act.wreg !== exp.wreg
        || (exp.wreg && (act.wd !== exp.wd || act.wdata !== exp.wdata))) begin
        errors++;
        $display("Error %s: expected wreg=%0b wd=%0d wdata=%08h, actual wreg=%0b wd=%0d wdata=%08h",
                 test_name, exp.wreg, exp.wd, exp.wdata, act.wreg, act.wd, act.wdata);
    end
endtask

task automatic check_latency(input int exp, input int act);
    checks++;
    if (act != exp) begin
        errors++;
        $display("Error %s: expected latency %0d, actual latency %0d", test_name, exp, act);
    end
endtask

`endif

// File: dv/lsu_tb.sv
// load/store pipeline testbench: clock, reset, directed and random tests, compare
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int RAM_WORDS = 256;
    localparam int LATENCY   = 3;
    localparam logic [5:0] LOAD_OPC [7] = '{OPC_LB, OPC_LBU, OPC_LH, OPC_LHU,
                                            OPC_LW, OPC_LWL, OPC_LWR};
    localparam logic [5:0] STORE_OPC [5] = '{OPC_SB, OPC_SH, OPC_SW, OPC_SWL, OPC_SWR};

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    instr_t      instr_i;
    wb_t         wb_o;
    wb_t         exp_q [$];
    int          issue_q [$];
    int          cyc;
    int          issued;
    int          tests;
    int          test_errors;
    logic [31:0] seed;

    `include "lsu_tb_ref.svh"

    lsu_top #(
        .RAM_WORDS (RAM_WORDS)
    ) UUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_o          (wb_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc > issued + 200) begin
            $display("timeout: results stopped retiring at cycle %0d", cyc);
            $display("Test failed");
            $finish;
        end
    end

    // wb_o only changes on the rising edge
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (wb_o.valid !== 1'b0) begin
                report_failure("wb_o.valid is not low during reset");
            end
        end else if (wb_o.valid) begin
            if (exp_q.size() == 0) begin
                report_failure("a result retired with no instruction outstanding");
            end else begin
                check_wb(exp_q.pop_front(), wb_o);
                check_latency(LATENCY, cyc - issue_q.pop_front());
            end
        end
    end

    function automatic instr_t encode(input logic [5:0] opc, input int rs, input int rt,
                                      input int imm);
        return {opc, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    // r1 holds the base and is never a destination here
    function automatic instr_t random_instr(inout int last_load_rd);
        logic [5:0] opc;
        int         kind;
        int         rs;
        int         rt;
        int         imm;
        kind = rand_below(16);
        rt   = rand_below(8);
        imm  = rand_below(64);
        rs   = 1;
        if (rt == 1 || rt == last_load_rd) begin
            rt = 0;
        end
        if (kind < 5) begin
            opc = OPC_ADDIU;
            rs  = rand_below(8);
            imm = rand_below(65536);
            if (rs == last_load_rd) begin
                rs = 0;
            end
        end else if (kind < 10) begin
            opc = LOAD_OPC[rand_below(7)];
        end else if (kind < 15) begin
            opc = STORE_OPC[rand_below(5)];
        end else begin
            opc = 6'b000000;
        end
        if (opc == OPC_LW || opc == OPC_SW) begin
            imm = imm & ~3;
        end
        last_load_rd = (kind >= 5 && kind < 10) ? rt : 0;
        return encode(opc, rs, rt, imm);
    endfunction

    task automatic issue(input instr_t i);
        @(negedge clk_i);
        instr_valid_i = 1'b1;
        instr_i       = i;
        exp_q.push_back(ref_exec(i));
        issue_q.push_back(cyc);
        issued++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        // results in flight get a few cycles to retire
        while (exp_q.size() != 0 && waited < 2 * LATENCY) begin
            @(negedge clk_i);
            waited++;
        end
        tests++;
        $display("%-14s %0d errors", test_name, errors - test_errors);
    endtask

    // restore the word from r6, store r5 over it, read it back
    task automatic store_readback(input logic [5:0] opc, input int word, input int off);
        issue(encode(OPC_SW, 1, 6, word));
        issue(encode(opc, 1, 5, word + off));
        issue(encode(OPC_LW, 1, 2, word));
    endtask

    initial begin
        logic [15:0] pat [4];
        int          last_rd;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cyc           = 0;
        issued        = 0;
        tests         = 0;
        checks        = 0;
        errors        = 0;
        seed          = 32'h7023;
        pat           = '{16'h1122, 16'h3344, 16'hA1B2, 16'hC3D4};
        for (int r = 0; r < 32; r++) begin
            rf_m[r] = 32'd0;
        end
        begin_test("reset");
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (4) @(negedge clk_i);
        end_test();

        begin_test("addiu_chain");
        issue(encode(OPC_ADDIU, 0, 1, 'h100));
        issue(encode(OPC_ADDIU, 0, 2, 5));
        issue(encode(OPC_ADDIU, 2, 2, 7));
        issue(encode(OPC_ADDIU, 2, 3, -3));
        issue(encode(OPC_ADDIU, 2, 4, 'h7000));
        issue(encode(OPC_ADDIU, 2, 5, -100));
        issue(encode(OPC_ADDIU, 4, 0, 9));
        issue(encode(OPC_ADDIU, 0, 6, 1));
        issue(encode(OPC_ADDIU, 6, 6, 'h8000));
        end_test();

        begin_test("load_narrow");
        issue(encode(OPC_ADDIU, 0, 5, 'h80F1));
        issue(encode(OPC_ADDIU, 0, 6, 'h7F12));
        issue(encode(OPC_SW, 1, 5, 0));
        issue(encode(OPC_SW, 1, 6, 4));
        for (int a = 0; a < 8; a++) begin
            issue(encode(OPC_LB, 1, 2, a));
            issue(encode(OPC_LBU, 1, 3, a));
            issue(encode(OPC_LH, 1, 2, a));
            issue(encode(OPC_LHU, 1, 3, a));
        end
        end_test();

        begin_test("store_narrow");
        for (int a = 0; a < 4; a++) begin
            store_readback(OPC_SB, 'h30, a);
            store_readback(OPC_SH, 'h34, a);
        end
        // halfwords build 11223344 at 0x110 and a1b2c3d4 at 0x114
        for (int k = 0; k < 4; k++) begin
            issue(encode(OPC_ADDIU, 0, 7, int'(pat[k])));
            issue(encode(OPC_SH, 1, 7, 'h10 + 2 * k));
        end
        issue(encode(OPC_LW, 1, 6, 'h10));
        issue(encode(OPC_LW, 1, 5, 'h14));
        end_test();

        begin_test("load_unaligned");
        for (int a = 0; a < 4; a++) begin
            issue(encode(OPC_ADDIU, 6, 2, 0));
            issue(encode(OPC_LWL, 1, 2, 'h14 + a));
            issue(encode(OPC_ADDIU, 6, 3, 0));
            issue(encode(OPC_LWR, 1, 3, 'h14 + a));
        end
        end_test();

        begin_test("store_unaligned");
        for (int a = 0; a < 4; a++) begin
            store_readback(OPC_SWL, 'h20, a);
            store_readback(OPC_SWR, 'h24, a);
        end
        end_test();

        begin_test("random_mix");
        for (int k = 0; k < 16; k++) begin
            issue(encode(OPC_ADDIU, 0, 2, rand_below(65536)));
            issue(encode(OPC_SW, 1, 2, 4 * k));
        end
        last_rd = 0;
        for (int k = 0; k < 300; k++) begin
            issue(random_instr(last_rd));
        end
        end_test();

        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d results never retired", exp_q.size()));
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: mips_lsu.f
+incdir+dv
rtl/lsu_pkg.sv
rtl/lsu_regfile.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_mem_access.sv
rtl/lsu_data_ram.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

// File: rtl/lsu_data_ram.sv
// word-wide data RAM, byte enables, asynchronous read, synchronous write
`timescale 1ns/1ps

module lsu_data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic               clk_i,
    input  lsu_pkg::mem_req_t  req_i,
    output lsu_pkg::mem_word_u rdata_o
);
    import lsu_pkg::*;

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    mem_word_u     mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // word index wraps at the RAM depth
    assign idx = AW'(req_i.addr[31:2] % RAM_WORDS);

    always_ff @(posedge clk_i) begin
        if (req_i.ce && req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.sel[i]) begin
                    mem[idx].lane[i] <= req_i.wdata.lane[i];
                end
            end
        end
    end

    assign rdata_o = mem[idx];

endmodule

// File: rtl/lsu_decode.sv
// opcode decode, operand read with forwarding, decode stage register
`timescale 1ns/1ps

module lsu_decode (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             instr_valid_i,
    input  lsu_pkg::instr_t  instr_i,
    input  lsu_pkg::wb_t     ex_fwd_i,
    input  lsu_pkg::wb_t     mem_fwd_i,
    input  logic [31:0]      rdata1_i,
    input  logic [31:0]      rdata2_i,
    output logic [4:0]       raddr1_o,
    output logic [4:0]       raddr2_o,
    output lsu_pkg::dec_t    dec_o
);
    import lsu_pkg::*;

    lsu_op_e op;
    logic    writes_rt;
    dec_t    dec_d;

    // youngest producer first, the regfile covers the result stage
    function automatic logic [31:0] operand(input logic [4:0]  ra,
                                            input logic [31:0] rf,
                                            input wb_t         ex_f,
                                            input wb_t         mem_f);
        if (ex_f.valid && ex_f.wreg && (ex_f.wd == ra)) begin
            return ex_f.wdata;
        end
        if (mem_f.valid && mem_f.wreg && (mem_f.wd == ra)) begin
            return mem_f.wdata;
        end
        return rf;
    endfunction

    assign raddr1_o = instr_i.rs;
    assign raddr2_o = instr_i.rt;

    always_comb begin
        case (instr_i.opcode)
            OPC_ADDIU: op = ADDIU;
            OPC_LB:    op = LB;
            OPC_LBU:   op = LBU;
            OPC_LH:    op = LH;
            OPC_LHU:   op = LHU;
            OPC_LW:    op = LW;
            OPC_LWL:   op = LWL;
            OPC_LWR:   op = LWR;
            OPC_SB:    op = SB;
            OPC_SH:    op = SH;
            OPC_SW:    op = SW;
            OPC_SWL:   op = SWL;
            OPC_SWR:   op = SWR;
            default:   op = NOP;
        endcase
    end

    assign writes_rt = op inside {ADDIU, LB, LBU, LH, LHU, LW, LWL, LWR};

    always_comb begin
        dec_d.valid = instr_valid_i;
        dec_d.op    = op;
        dec_d.wd    = instr_i.rt;
        dec_d.wreg  = writes_rt && (instr_i.rt != 5'd0);
        dec_d.reg1  = operand(instr_i.rs, rdata1_i, ex_fwd_i, mem_fwd_i);
        dec_d.reg2  = operand(instr_i.rt, rdata2_i, ex_fwd_i, mem_fwd_i);
        dec_d.simm  = {{16{instr_i.imm[15]}}, instr_i.imm};
    end

    always_ff @(posedge clk_i) begin
        dec_o <= dec_d;
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/lsu_execute.sv
// address and ADDIU adder, early forward, execute stage register
`timescale 1ns/1ps

module lsu_execute (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  lsu_pkg::dec_t  dec_i,
    output lsu_pkg::wb_t   fwd_o,
    output lsu_pkg::ex_t   ex_o
);
    import lsu_pkg::*;

    logic [31:0] sum;
    ex_t         ex_d;

    // same adder serves ADDIU and the effective address
    assign sum = dec_i.reg1 + dec_i.simm;

    // loads are not ready yet, only ADDIU forwards from here
    always_comb begin
        fwd_o.valid = dec_i.valid && (dec_i.op == ADDIU);
        fwd_o.wreg  = dec_i.wreg;
        fwd_o.wd    = dec_i.wd;
        fwd_o.wdata = sum;
    end

    always_comb begin
        ex_d.valid = dec_i.valid;
        ex_d.op    = dec_i.op;
        ex_d.wd    = dec_i.wd;
        ex_d.wreg  = dec_i.wreg;
        ex_d.addr  = sum;
        ex_d.reg2  = dec_i.reg2;
    end

    always_ff @(posedge clk_i) begin
        ex_o <= ex_d;
        if (!rst_n_i) begin
            ex_o.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/lsu_mem_access.sv
// byte select, store data placement and load extraction for all load/store forms
`timescale 1ns/1ps

module lsu_mem_access (
    input  lsu_pkg::ex_t       ex_i,
    input  lsu_pkg::mem_word_u rdata_i,
    output lsu_pkg::mem_req_t  req_o,
    output lsu_pkg::wb_t       wb_o
);
    import lsu_pkg::*;

    logic [1:0]  off;
    logic [1:0]  lane;
    logic [4:0]  sh_left;
    logic [4:0]  sh_right;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic        half_ok;
    logic [3:0]  half_sel;
    logic [31:0] rd_word;
    logic [31:0] word_addr;
    logic        is_load;
    logic        is_store;

    assign off = ex_i.addr[1:0];
    // big-endian, offset n sits in lane 3-n
    assign lane     = ~off;
    assign sh_left  = {off, 3'b000};
    assign sh_right = {lane, 3'b000};

    assign rd_byte  = rdata_i.lane[lane];
    assign rd_half  = rdata_i.half[~off[1]];
    assign rd_word  = rdata_i;
    assign half_ok  = ~off[0];
    assign half_sel = half_ok ? (off[1] ? 4'b0011 : 4'b1100) : 4'b0000;

    // unaligned word forms work on the enclosing word
    assign word_addr = {ex_i.addr[31:2], 2'b00};

    assign is_load  = ex_i.op inside {LB, LBU, LH, LHU, LW, LWL, LWR};
    assign is_store = ex_i.op inside {SB, SH, SW, SWL, SWR};

    always_comb begin
        req_o.ce    = ex_i.valid && (is_load || is_store);
        req_o.we    = ex_i.valid && is_store;
        req_o.sel   = 4'b0000;
        req_o.addr  = ex_i.addr;
        req_o.wdata = ex_i.reg2;

        wb_o.valid = ex_i.valid;
        wb_o.wreg  = ex_i.wreg;
        wb_o.wd    = ex_i.wd;
        wb_o.wdata = 32'd0;

        case (ex_i.op)
            ADDIU: wb_o.wdata = ex_i.addr;
            LB: begin
                req_o.sel  = 4'b0001 << lane;
                wb_o.wdata = {{24{rd_byte[7]}}, rd_byte};
            end
            LBU: begin
                req_o.sel  = 4'b0001 << lane;
                wb_o.wdata = {24'd0, rd_byte};
            end
            // misaligned halfword loads return zero
            LH: begin
                req_o.sel  = half_sel;
                wb_o.wdata = half_ok ? {{16{rd_half[15]}}, rd_half} : 32'd0;
            end
            LHU: begin
                req_o.sel  = half_sel;
                wb_o.wdata = half_ok ? {16'd0, rd_half} : 32'd0;
            end
            LW: begin
                req_o.sel  = 4'b1111;
                wb_o.wdata = rd_word;
            end
            // memory moves up, rt fills the low 8n bits
            LWL: begin
                req_o.addr = word_addr;
                req_o.sel  = 4'b1111;
                wb_o.wdata = (rd_word << sh_left)
                           | (ex_i.reg2 & ~(32'hffff_ffff << sh_left));
            end
            // top n+1 memory bytes land in the low end of rt
            LWR: begin
                req_o.addr = word_addr;
                req_o.sel  = 4'b1111;
                wb_o.wdata = (rd_word >> sh_right)
                           | (ex_i.reg2 & ~(32'hffff_ffff >> sh_right));
            end
            SB: begin
                req_o.sel   = 4'b0001 << lane;
                req_o.wdata = {4{ex_i.reg2[7:0]}};
            end
            // sel stays empty when misaligned, so nothing is written
            SH: begin
                req_o.sel   = half_sel;
                req_o.wdata = {2{ex_i.reg2[15:0]}};
            end
            SW: begin
                req_o.sel = 4'b1111;
            end
            SWL: begin
                req_o.addr  = word_addr;
                req_o.sel   = 4'b1111 >> off;
                req_o.wdata = ex_i.reg2 >> sh_left;
            end
            SWR: begin
                req_o.addr  = word_addr;
                req_o.sel   = 4'b1111 << lane;
                req_o.wdata = ex_i.reg2 << sh_right;
            end
            default: wb_o.wdata = 32'd0;
        endcase
    end

endmodule

// File: rtl/lsu_pkg.sv
// opcodes, operation enum, instruction and stage structs, memory word union
package lsu_pkg;

    // standard MIPS major opcodes
    localparam logic [5:0] OPC_ADDIU = 6'b001001;
    localparam logic [5:0] OPC_LB    = 6'b100000;
    localparam logic [5:0] OPC_LH    = 6'b100001;
    localparam logic [5:0] OPC_LWL   = 6'b100010;
    localparam logic [5:0] OPC_LW    = 6'b100011;
    localparam logic [5:0] OPC_LBU   = 6'b100100;
    localparam logic [5:0] OPC_LHU   = 6'b100101;
    localparam logic [5:0] OPC_LWR   = 6'b100110;
    localparam logic [5:0] OPC_SB    = 6'b101000;
    localparam logic [5:0] OPC_SH    = 6'b101001;
    localparam logic [5:0] OPC_SWL   = 6'b101010;
    localparam logic [5:0] OPC_SW    = 6'b101011;
    localparam logic [5:0] OPC_SWR   = 6'b101110;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_t;

    typedef enum logic [4:0] {
        NOP, ADDIU,
        LB, LBU, LH, LHU, LW, LWL, LWR,
        SB, SH, SW, SWL, SWR
    } lsu_op_e;

    // lane 3 holds byte offset 0 (big-endian)
    typedef union packed {
        logic [3:0][7:0]  lane;
        logic [1:0][15:0] half;
    } mem_word_u;

    typedef struct packed {
        logic        valid;
        lsu_op_e     op;
        logic [4:0]  wd;
        logic        wreg;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic [31:0] simm;
    } dec_t;

    typedef struct packed {
        logic        valid;
        lsu_op_e     op;
        logic [4:0]  wd;
        logic        wreg;
        logic [31:0] addr;
        logic [31:0] reg2;
    } ex_t;

    typedef struct packed {
        logic        ce;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] addr;
        mem_word_u   wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] wdata;
    } wb_t;

endpackage

// File: rtl/lsu_regfile.sv
// 32x32 register file, two write-through read ports, one write port
`timescale 1ns/1ps

module lsu_regfile (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic [4:0]    raddr1_i,
    input  logic [4:0]    raddr2_i,
    output logic [31:0]   rdata1_o,
    output logic [31:0]   rdata2_o,
    input  lsu_pkg::wb_t  wb_i
);

    logic [31:0] regs [0:31];
    logic        we;

    // r0 is never written
    assign we = wb_i.valid && wb_i.wreg && (wb_i.wd != 5'd0);

    function automatic logic [31:0] read_port(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return 32'd0;
        end
        if (we && (wb_i.wd == ra)) begin
            return wb_i.wdata;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we) begin
            regs[wb_i.wd] <= wb_i.wdata;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

// File: rtl/lsu_result.sv
// result stage register, retirement point and register file write source
`timescale 1ns/1ps

module lsu_result (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  lsu_pkg::wb_t  wb_i,
    output lsu_pkg::wb_t  wb_o
);

    // one cycle after memory access, then into the regfile
    always_ff @(posedge clk_i) begin
        wb_o <= wb_i;
        if (!rst_n_i) begin
            wb_o.valid <= 1'b0;
        end
    end

endmodule

// File: rtl/lsu_top.sv
// load/store pipeline top: stages, register file and data RAM
`timescale 1ns/1ps

module lsu_top #(
    parameter int RAM_WORDS = 256
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             instr_valid_i,
    input  lsu_pkg::instr_t  instr_i,
    output lsu_pkg::wb_t     wb_o
);
    import lsu_pkg::*;

    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    dec_t        dec;
    ex_t         ex;
    wb_t         ex_fwd;
    wb_t         mem_wb;
    mem_req_t    mem_req;
    mem_word_u   mem_rdata;

    lsu_regfile u_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wb_i     (wb_o)
    );

    lsu_decode u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_wb),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .dec_o         (dec)
    );

    lsu_execute u_execute (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_i   (dec),
        .fwd_o   (ex_fwd),
        .ex_o    (ex)
    );

    lsu_mem_access u_mem_access (
        .ex_i    (ex),
        .rdata_i (mem_rdata),
        .req_o   (mem_req),
        .wb_o    (mem_wb)
    );

    lsu_data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk_i   (clk_i),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    lsu_result u_result (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wb_i    (mem_wb),
        .wb_o    (wb_o)
    );

endmodule
